//--- logic/sat_pkg.sv
// fixed format of 4 bins with 4 variables each; a clause may only use variables of its own or earlier bins
package sat_pkg;

    localparam int NUM_BINS        = 4;
    localparam int VARS_PER_BIN    = 4;
    localparam int NUM_VARS        = NUM_BINS * VARS_PER_BIN;
    localparam int VAR_IDX_W       = 4;
    localparam int CLAUSES_PER_BIN = 4;
    localparam int LITS_PER_CLAUSE = 3;

    // literal is {valid, negate, var index}
    localparam int LIT_W       = 2 + VAR_IDX_W;
    localparam int LIT_NEG_BIT = VAR_IDX_W;
    localparam int LIT_VLD_BIT = VAR_IDX_W + 1;
    localparam int CLAUSE_W    = LITS_PER_CLAUSE * LIT_W;

    // bin numbers are 1-based, 0 means before the first bin
    localparam int BIN_ID_W  = 3;
    localparam int BIN_IDX_W = 2;
    localparam int SLOT_W    = 2;

    // store address is {bin index, slot}
    localparam int STORE_ADDR_W = BIN_IDX_W + SLOT_W;

    localparam int LVL_W = 5;

    // candidate counter carries one extra bit to mark an exhausted bin
    localparam int NUM_CANDS = 2 ** VARS_PER_BIN;
    localparam int CNT_W     = VARS_PER_BIN + 1;

endpackage

//--- logic/bm_ctrl_pkg.sv
// controller states and start pulse indices; the state encoding fits in 3 bits
package bm_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        RD_BIN_INFO,
        LOAD_BIN,
        RUN_CORE,
        UPDATE_BIN,
        GLOBAL_SAT,
        GLOBAL_UNSAT
    } bm_state_e;

    localparam int NUM_STARTS = 4;
    localparam int ST_RDINFO  = 0;
    localparam int ST_LOAD    = 1;
    localparam int ST_CORE    = 2;
    localparam int ST_UPDATE  = 3;

endpackage

//--- logic/clause_lane.sv
// a clause without any valid literal reads as satisfied
`timescale 1ns/1ps

module clause_lane (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         load_en_i,
    input  logic [sat_pkg::CLAUSE_W-1:0] load_clause_i,
    input  logic [sat_pkg::NUM_VARS-1:0] assign_i,
    output logic                         clause_sat_o
);

    import sat_pkg::*;

    logic [CLAUSE_W-1:0] clause_r;
    logic                any_vld;
    logic                any_true;

    always_ff @(posedge clk)
    begin
        if (!rst)
            clause_r <= '0;
        else if (load_en_i)
            clause_r <= load_clause_i;
    end

    always_comb
    begin : eval
        logic [LIT_W-1:0] lit;
        any_vld  = 1'b0;
        any_true = 1'b0;
        for (int k = 0; k < LITS_PER_CLAUSE; k++)
        begin
            lit = clause_r[k*LIT_W +: LIT_W];
            if (lit[LIT_VLD_BIT])
            begin
                any_vld  = 1'b1;
                any_true = any_true | (assign_i[lit[VAR_IDX_W-1:0]] ^ lit[LIT_NEG_BIT]);
            end
        end
    end

    assign clause_sat_o = !any_vld || any_true;

endmodule

//--- logic/clause_store.sv
// clause memory has no reset so every slot of a used bin must be written before start
`timescale 1ns/1ps

module clause_store (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                cfg_we_i,
    input  logic [sat_pkg::STORE_ADDR_W-1:0]    cfg_addr_i,
    input  logic [sat_pkg::CLAUSE_W-1:0]        cfg_clause_i,
    input  logic [sat_pkg::BIN_ID_W-1:0]        nb_bins_i,
    input  logic                                start_rdinfo_i,
    output logic                                done_rdinfo_o,
    output logic [sat_pkg::BIN_ID_W-1:0]        nb_all_o,
    input  logic                                start_load_i,
    input  logic [sat_pkg::BIN_ID_W-1:0]        request_bin_i,
    output logic                                done_load_o,
    output logic [sat_pkg::CLAUSES_PER_BIN-1:0] load_en_o,
    output logic [sat_pkg::CLAUSE_W-1:0]        load_clause_o
);

    import sat_pkg::*;

    logic [CLAUSE_W-1:0]  mem_r [NUM_BINS*CLAUSES_PER_BIN];
    logic [BIN_ID_W-1:0]  nb_all_r;
    logic                 busy_r;
    logic [SLOT_W-1:0]    slot_r;
    logic [BIN_IDX_W-1:0] bin_idx_r;
    logic [BIN_ID_W-1:0]  req_m1;

    always_ff @(posedge clk)
    begin
        if (cfg_we_i)
            mem_r[cfg_addr_i] <= cfg_clause_i;
    end

    // request is 1-based
    assign req_m1 = request_bin_i - 1'b1;

    always_ff @(posedge clk)
    begin
        if (start_load_i)
            bin_idx_r <= req_m1[BIN_IDX_W-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            nb_all_r      <= '0;
            done_rdinfo_o <= 1'b0;
            done_load_o   <= 1'b0;
            busy_r        <= 1'b0;
            slot_r        <= '0;
        end
        else
        begin
            done_rdinfo_o <= start_rdinfo_i;
            if (start_rdinfo_i)
                nb_all_r <= nb_bins_i;
            done_load_o <= busy_r && (slot_r == SLOT_W'(CLAUSES_PER_BIN - 1));
            if (start_load_i)
            begin
                busy_r <= 1'b1;
                slot_r <= '0;
            end
            else if (busy_r)
            begin
                slot_r <= slot_r + 1'b1;
                if (slot_r == SLOT_W'(CLAUSES_PER_BIN - 1))
                    busy_r <= 1'b0;
            end
        end
    end

    // one lane per cycle
    always_comb
    begin
        load_en_o = '0;
        if (busy_r)
            load_en_o[slot_r] = 1'b1;
    end

    assign load_clause_o = mem_r[{bin_idx_r, slot_r}];
    assign nb_all_o      = nb_all_r;

endmodule

//--- logic/bin_search.sv
// one candidate per cycle in increasing order; the lanes must evaluate combinationally
`timescale 1ns/1ps

module bin_search (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [sat_pkg::BIN_ID_W-1:0]        cur_bin_i,
    input  logic                                start_core_i,
    output logic                                done_core_o,
    output logic                                local_sat_o,
    output logic [sat_pkg::LVL_W-1:0]           core_lvl_o,
    output logic [sat_pkg::BIN_ID_W-1:0]        bkt_bin_o,
    input  logic                                start_update_i,
    output logic                                done_update_o,
    input  logic [sat_pkg::CLAUSES_PER_BIN-1:0] lane_sat_i,
    output logic [sat_pkg::NUM_VARS-1:0]        assign_o
);

    import sat_pkg::*;

    logic [NUM_VARS-1:0]  assign_r;
    logic [CNT_W-1:0]     cnt_r [NUM_BINS];
    logic                 running_r;
    logic                 trial_vld_r;
    logic [CNT_W-1:0]     trial_r;
    logic [BIN_ID_W-1:0]  bin_r;
    logic [BIN_ID_W-1:0]  bin_m1;
    logic [BIN_ID_W-1:0]  cur_m1;
    logic [BIN_IDX_W-1:0] bin_idx;
    logic [BIN_IDX_W-1:0] start_idx;
    logic                 exhausted;
    logic                 scan_hit;
    logic                 scan_fail;
    logic                 scan_step;

    assign bin_m1    = bin_r - 1'b1;
    assign cur_m1    = cur_bin_i - 1'b1;
    assign bin_idx   = bin_m1[BIN_IDX_W-1:0];
    assign start_idx = cur_m1[BIN_IDX_W-1:0];

    // counter at NUM_CANDS means nothing is left to try
    assign exhausted = (trial_r == CNT_W'(NUM_CANDS));
    assign scan_hit  = running_r && !exhausted && (&lane_sat_i);
    assign scan_fail = running_r && !scan_hit
                     && (exhausted || trial_r == CNT_W'(NUM_CANDS - 1));
    assign scan_step = running_r && !scan_hit && !scan_fail;

    always_ff @(posedge clk)
    begin
        if (start_core_i)
        begin
            bin_r   <= cur_bin_i;
            trial_r <= cnt_r[start_idx];
        end
        else if (scan_step)
            trial_r <= trial_r + 1'b1;
        if (scan_hit || scan_fail)
        begin
            local_sat_o <= scan_hit;
            bkt_bin_o   <= bin_m1;
            core_lvl_o  <= LVL_W'(scan_hit ? bin_r : bin_m1) * LVL_W'(VARS_PER_BIN);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            running_r     <= 1'b0;
            trial_vld_r   <= 1'b0;
            done_core_o   <= 1'b0;
            done_update_o <= 1'b0;
            assign_r      <= '0;
            for (int b = 0; b < NUM_BINS; b++)
                cnt_r[b] <= '0;
        end
        else
        begin
            done_core_o   <= scan_hit || scan_fail;
            done_update_o <= start_update_i;
            if (start_core_i)
            begin
                running_r   <= 1'b1;
                trial_vld_r <= 1'b1;
            end
            else if (scan_hit)
                running_r <= 1'b0;
            else if (scan_fail)
            begin
                // a later return to this bin starts over from zero
                running_r   <= 1'b0;
                trial_vld_r <= 1'b0;
                cnt_r[bin_idx] <= '0;
                assign_r[bin_idx*VARS_PER_BIN +: VARS_PER_BIN] <= '0;
            end
            else if (start_update_i)
            begin
                trial_vld_r <= 1'b0;
                cnt_r[bin_idx] <= trial_r + 1'b1;
                assign_r[bin_idx*VARS_PER_BIN +: VARS_PER_BIN] <= trial_r[VARS_PER_BIN-1:0];
            end
        end
    end

    // trial value replaces the current bin's committed variables
    always_comb
    begin
        assign_o = assign_r;
        if (trial_vld_r)
            assign_o[bin_idx*VARS_PER_BIN +: VARS_PER_BIN] = trial_r[VARS_PER_BIN-1:0];
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!rst) start_core_i |-> !running_r)
        else $error("start_core while scan is running");

endmodule

//--- logic/bin_ctrl.sv
// runs bins in order with chronological backtracking; nb_all_i must lie in 1 to NUM_BINS
`timescale 1ns/1ps

module bin_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start_i,
    output logic                         done_o,
    output logic                         sat_o,
    output logic                         unsat_o,
    output logic [sat_pkg::BIN_ID_W-1:0] cur_bin_o,
    output logic [sat_pkg::LVL_W-1:0]    cur_lvl_o,
    output logic                         start_rdinfo_o,
    input  logic                         done_rdinfo_i,
    input  logic [sat_pkg::BIN_ID_W-1:0] nb_all_i,
    output logic                         start_load_o,
    input  logic                         done_load_i,
    output logic                         start_core_o,
    input  logic                         done_core_i,
    input  logic                         local_sat_i,
    input  logic [sat_pkg::LVL_W-1:0]    core_lvl_i,
    input  logic [sat_pkg::BIN_ID_W-1:0] bkt_bin_i,
    output logic                         start_update_o,
    input  logic                         done_update_i
);

    import sat_pkg::*;
    import bm_ctrl_pkg::*;

    bm_state_e             state_r;
    bm_state_e             state_n;
    logic                  entry_r;
    logic [BIN_ID_W-1:0]   cur_bin_r;
    logic [NUM_STARTS-1:0] starts;

    always_comb
    begin
        state_n = state_r;
        case (state_r)
            IDLE:
                if (start_i)
                    state_n = RD_BIN_INFO;
            RD_BIN_INFO:
                if (done_rdinfo_i)
                    state_n = LOAD_BIN;
            LOAD_BIN:
                if (done_load_i)
                    state_n = RUN_CORE;
            RUN_CORE:
                if (done_core_i)
                begin
                    if (local_sat_i && cur_bin_r == nb_all_i)
                        state_n = GLOBAL_SAT;
                    else if (local_sat_i)
                        state_n = UPDATE_BIN;
                    else if (bkt_bin_i == '0)
                        state_n = GLOBAL_UNSAT;
                    else
                        state_n = LOAD_BIN;
                end
            UPDATE_BIN:
                if (done_update_i)
                    state_n = LOAD_BIN;
            GLOBAL_SAT,
            GLOBAL_UNSAT:
                state_n = state_r;
            default:
                state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state_r <= IDLE;
            entry_r <= 1'b0;
        end
        else
        begin
            state_r <= state_n;
            // high in the first cycle of a new state
            entry_r <= (state_n != state_r);
        end
    end

    // each start fires in the second cycle of its state
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            start_rdinfo_o <= 1'b0;
            start_load_o   <= 1'b0;
            start_core_o   <= 1'b0;
            start_update_o <= 1'b0;
        end
        else
        begin
            start_rdinfo_o <= entry_r && (state_r == RD_BIN_INFO);
            start_load_o   <= entry_r && (state_r == LOAD_BIN);
            start_core_o   <= entry_r && (state_r == RUN_CORE);
            start_update_o <= entry_r && (state_r == UPDATE_BIN);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            cur_bin_r <= BIN_ID_W'(1);
            cur_lvl_o <= '0;
        end
        else
        begin
            if (state_r == UPDATE_BIN && done_update_i)
                cur_bin_r <= cur_bin_r + 1'b1;
            else if (state_r == RUN_CORE && done_core_i && !local_sat_i && bkt_bin_i != '0)
                cur_bin_r <= bkt_bin_i;
            if (state_r == RUN_CORE && done_core_i)
                cur_lvl_o <= core_lvl_i;
        end
    end

    // final flags hold until reset
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            done_o  <= 1'b0;
            sat_o   <= 1'b0;
            unsat_o <= 1'b0;
        end
        else
        begin
            if (state_r == GLOBAL_SAT)
            begin
                done_o <= 1'b1;
                sat_o  <= 1'b1;
            end
            if (state_r == GLOBAL_UNSAT)
            begin
                done_o  <= 1'b1;
                unsat_o <= 1'b1;
            end
        end
    end

    assign cur_bin_o = cur_bin_r;

    assign starts[ST_RDINFO] = start_rdinfo_o;
    assign starts[ST_LOAD]   = start_load_o;
    assign starts[ST_CORE]   = start_core_o;
    assign starts[ST_UPDATE] = start_update_o;

    // a unit answers no earlier than the cycle after its start
    a_pulse_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({starts, done_rdinfo_i, done_load_i, done_core_i, done_update_i}))
        else $error("start and done pulses overlap");

    a_result_excl: assert property (@(posedge clk) disable iff (!rst) !(sat_o && unsat_o))
        else $error("sat and unsat both set");

endmodule

//--- logic/bin_solver_top.sv
// nb_bins_i is sampled once per run and clauses must be written before start_i
`timescale 1ns/1ps

module bin_solver_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cfg_we_i,
    input  logic [sat_pkg::STORE_ADDR_W-1:0] cfg_addr_i,
    input  logic [sat_pkg::CLAUSE_W-1:0]     cfg_clause_i,
    input  logic [sat_pkg::BIN_ID_W-1:0]     nb_bins_i,
    input  logic                             start_i,
    output logic                             done_o,
    output logic                             sat_o,
    output logic                             unsat_o,
    output logic [sat_pkg::BIN_ID_W-1:0]     cur_bin_o,
    output logic [sat_pkg::LVL_W-1:0]        cur_lvl_o,
    output logic [sat_pkg::NUM_VARS-1:0]     assign_o
);

    import sat_pkg::*;

    logic                       start_rdinfo;
    logic                       done_rdinfo;
    logic [BIN_ID_W-1:0]        nb_all;
    logic                       start_load;
    logic                       done_load;
    logic                       start_core;
    logic                       done_core;
    logic                       local_sat;
    logic [LVL_W-1:0]           core_lvl;
    logic [BIN_ID_W-1:0]        bkt_bin;
    logic                       start_update;
    logic                       done_update;
    logic [CLAUSES_PER_BIN-1:0] load_en;
    logic [CLAUSE_W-1:0]        load_clause;
    logic [CLAUSES_PER_BIN-1:0] lane_sat;

    bin_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .start_i        (start_i),
        .done_o         (done_o),
        .sat_o          (sat_o),
        .unsat_o        (unsat_o),
        .cur_bin_o      (cur_bin_o),
        .cur_lvl_o      (cur_lvl_o),
        .start_rdinfo_o (start_rdinfo),
        .done_rdinfo_i  (done_rdinfo),
        .nb_all_i       (nb_all),
        .start_load_o   (start_load),
        .done_load_i    (done_load),
        .start_core_o   (start_core),
        .done_core_i    (done_core),
        .local_sat_i    (local_sat),
        .core_lvl_i     (core_lvl),
        .bkt_bin_i      (bkt_bin),
        .start_update_o (start_update),
        .done_update_i  (done_update)
    );

    clause_store u_store (
        .clk            (clk),
        .rst            (rst),
        .cfg_we_i       (cfg_we_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_clause_i   (cfg_clause_i),
        .nb_bins_i      (nb_bins_i),
        .start_rdinfo_i (start_rdinfo),
        .done_rdinfo_o  (done_rdinfo),
        .nb_all_o       (nb_all),
        .start_load_i   (start_load),
        .request_bin_i  (cur_bin_o),
        .done_load_o    (done_load),
        .load_en_o      (load_en),
        .load_clause_o  (load_clause)
    );

    for (genvar g = 0; g < CLAUSES_PER_BIN; g++)
    begin : g_lane
        clause_lane u_lane (
            .clk           (clk),
            .rst           (rst),
            .load_en_i     (load_en[g]),
            .load_clause_i (load_clause),
            .assign_i      (assign_o),
            .clause_sat_o  (lane_sat[g])
        );
    end

    bin_search u_search (
        .clk            (clk),
        .rst            (rst),
        .cur_bin_i      (cur_bin_o),
        .start_core_i   (start_core),
        .done_core_o    (done_core),
        .local_sat_o    (local_sat),
        .core_lvl_o     (core_lvl),
        .bkt_bin_o      (bkt_bin),
        .start_update_i (start_update),
        .done_update_o  (done_update),
        .lane_sat_i     (lane_sat),
        .assign_o       (assign_o)
    );

endmodule

//--- testbench/tb_bin_solver.sv
// each test resets the DUT and rewrites all clause slots; the reference search grows as 16 ** bins
`timescale 1ns/1ps

module tb_bin_solver;

    import sat_pkg::*;
    import bm_ctrl_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 16;
    localparam int NUM_TESTS   = 6;
    localparam int RUN_CYCLES  = 65536 * 24 + 1000;
    localparam int WATCHDOG_NS = NUM_TESTS * RUN_CYCLES * CLK_PERIOD;
    localparam int NUM_SLOTS   = NUM_BINS * CLAUSES_PER_BIN;

    logic                    clk;
    logic                    rst;
    logic                    cfg_we_i;
    logic [STORE_ADDR_W-1:0] cfg_addr_i;
    logic [CLAUSE_W-1:0]     cfg_clause_i;
    logic [BIN_ID_W-1:0]     nb_bins_i;
    logic                    start_i;
    logic                    done_o;
    logic                    sat_o;
    logic                    unsat_o;
    logic [BIN_ID_W-1:0]     cur_bin_o;
    logic [LVL_W-1:0]        cur_lvl_o;
    logic [NUM_VARS-1:0]     assign_o;

    // clause image, index is bin index times slots plus slot
    logic [CLAUSE_W-1:0] clauses [NUM_SLOTS];
    int                  err_count;
    int                  tests_run;
    int                  tests_failed;

    bin_solver_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .cfg_we_i     (cfg_we_i),
        .cfg_addr_i   (cfg_addr_i),
        .cfg_clause_i (cfg_clause_i),
        .nb_bins_i    (nb_bins_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .sat_o        (sat_o),
        .unsat_o      (unsat_o),
        .cur_bin_o    (cur_bin_o),
        .cur_lvl_o    (cur_lvl_o),
        .assign_o     (assign_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
            err_count++;
        end
    endtask

    function automatic logic [LIT_W-1:0] make_lit(input int v_idx, input bit neg);
        return {1'b1, neg, VAR_IDX_W'(v_idx)};
    endfunction

    function automatic logic [CLAUSE_W-1:0] make_clause(input logic [LIT_W-1:0] l0,
                                                        input logic [LIT_W-1:0] l1,
                                                        input logic [LIT_W-1:0] l2);
        return {l2, l1, l0};
    endfunction

    task automatic clear_clauses();
        for (int i = 0; i < NUM_SLOTS; i++)
            clauses[i] = '0;
    endtask

    // a literal is true when the variable differs from its negate bit
    function automatic bit clause_holds(input logic [CLAUSE_W-1:0] c,
                                        input logic [NUM_VARS-1:0] a);
        logic [LIT_W-1:0] l;
        bit               used;
        bit               hit;
        used = 1'b0;
        hit  = 1'b0;
        for (int k = 0; k < LITS_PER_CLAUSE; k++)
        begin
            l = c[k*LIT_W +: LIT_W];
            if (l[LIT_W-1])
            begin
                used = 1'b1;
                if (a[l[VAR_IDX_W-1:0]] != l[VAR_IDX_W])
                    hit = 1'b1;
            end
        end
        return !used || hit;
    endfunction

    // brute force in lexicographic order, bin 1 is the top nibble of the count
    function automatic bit reference_solve(input int nb, output logic [NUM_VARS-1:0] sol);
        logic [NUM_VARS-1:0] a;
        bit                  ok;
        sol = '0;
        for (int v = 0; v < (1 << (VARS_PER_BIN * nb)); v++)
        begin
            a = '0;
            for (int b = 0; b < nb; b++)
                a[b*VARS_PER_BIN +: VARS_PER_BIN] =
                    VARS_PER_BIN'(v >> (VARS_PER_BIN * (nb - 1 - b)));
            ok = 1'b1;
            for (int i = 0; i < nb * CLAUSES_PER_BIN; i++)
                if (!clause_holds(clauses[i], a))
                    ok = 1'b0;
            if (ok)
            begin
                sol = a;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic apply_reset();
        rst      = 1'b0;
        start_i  = 1'b0;
        cfg_we_i = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b1;
    endtask

    task automatic write_clauses();
        for (int i = 0; i < NUM_SLOTS; i++)
        begin
            @(negedge clk);
            cfg_we_i     = 1'b1;
            cfg_addr_i   = STORE_ADDR_W'(i);
            cfg_clause_i = clauses[i];
        end
        @(negedge clk);
        cfg_we_i = 1'b0;
    endtask

    task automatic wait_done(output bit seen);
        int n;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < RUN_CYCLES)
        begin
            @(negedge clk);
            seen = done_o;
            n++;
        end
        if (!seen)
        begin
            $display("done_o did not rise within %0d cycles at t=%0t", RUN_CYCLES, $time);
            err_count++;
        end
    endtask

    task automatic run_solver(input int nb, output bit seen);
        apply_reset();
        write_clauses();
        nb_bins_i = BIN_ID_W'(nb);
        start_i   = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        wait_done(seen);
    endtask

    task automatic check_result(input int nb);
        logic [NUM_VARS-1:0] sol;
        bit                  found;
        found = reference_solve(nb, sol);
        check_value("sat_o", 32'(sat_o), 32'(found));
        check_value("unsat_o", 32'(unsat_o), 32'(!found));
        check_value("assign_o", 32'(assign_o), 32'(sol));
        if (found)
        begin
            check_value("cur_bin_o", 32'(cur_bin_o), 32'(nb));
            check_value("cur_lvl_o", 32'(cur_lvl_o), 32'(nb * VARS_PER_BIN));
        end
        else
        begin
            check_value("cur_bin_o", 32'(cur_bin_o), 32'(1));
            check_value("cur_lvl_o", 32'(cur_lvl_o), 32'(0));
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before)
            $display("test %s: pass", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, err_count - errs_before);
        end
    endtask

    task automatic check_after_reset();
        int e0;
        e0 = err_count;
        apply_reset();
        check_value("done_o", 32'(done_o), 32'(0));
        check_value("sat_o", 32'(sat_o), 32'(0));
        check_value("unsat_o", 32'(unsat_o), 32'(0));
        check_value("cur_bin_o", 32'(cur_bin_o), 32'(1));
        check_value("cur_lvl_o", 32'(cur_lvl_o), 32'(0));
        check_value("assign_o", 32'(assign_o), 32'(0));
        finish_test("reset", e0);
    endtask

    task automatic solve_forced_bin();
        int e0;
        bit seen;
        e0 = err_count;
        clear_clauses();
        // x0, not x1, x2, x3
        clauses[0] = make_clause(make_lit(0, 1'b0), LIT_W'(0), LIT_W'(0));
        clauses[1] = make_clause(make_lit(1, 1'b1), LIT_W'(0), LIT_W'(0));
        clauses[2] = make_clause(make_lit(2, 1'b0), LIT_W'(0), LIT_W'(0));
        clauses[3] = make_clause(make_lit(3, 1'b0), make_lit(3, 1'b0), make_lit(3, 1'b0));
        run_solver(1, seen);
        if (seen)
        begin
            check_result(1);
            check_value("assign_o forced", 32'(assign_o), 32'h000d);
        end
        finish_test("one_bin", e0);
    endtask

    task automatic solve_with_backtrack();
        int e0;
        bit seen;
        e0 = err_count;
        clear_clauses();
        clauses[0] = make_clause(make_lit(0, 1'b0), make_lit(1, 1'b0), LIT_W'(0));
        // bin 2 rules out x0, so bin 1 must move past its first value
        clauses[4] = make_clause(make_lit(0, 1'b1), make_lit(4, 1'b0), LIT_W'(0));
        clauses[5] = make_clause(make_lit(0, 1'b1), make_lit(4, 1'b1), LIT_W'(0));
        run_solver(2, seen);
        if (seen)
        begin
            check_result(2);
            check_value("cur_lvl_o", 32'(cur_lvl_o), 32'(8));
        end
        finish_test("backtrack", e0);
    endtask

    task automatic detect_unsat();
        int e0;
        bit seen;
        e0 = err_count;
        clear_clauses();
        clauses[4] = make_clause(make_lit(4, 1'b0), LIT_W'(0), LIT_W'(0));
        clauses[5] = make_clause(make_lit(4, 1'b1), LIT_W'(0), LIT_W'(0));
        run_solver(2, seen);
        if (seen)
        begin
            check_result(2);
            // result must hold after done
            repeat (8)
            begin
                @(negedge clk);
                check_value("sat_o", 32'(sat_o), 32'(0));
                check_value("unsat_o", 32'(unsat_o), 32'(1));
            end
        end
        finish_test("unsat", e0);
    endtask

    task automatic solve_random_bins();
        int e0;
        bit seen;
        int top;
        e0 = err_count;
        clear_clauses();
        for (int b = 0; b < 3; b++)
        begin
            top = VARS_PER_BIN * (b + 1) - 1;
            for (int s = 0; s < CLAUSES_PER_BIN; s++)
                if (s < 3 || 1'($urandom))
                    clauses[b*CLAUSES_PER_BIN + s] = make_clause(
                        make_lit(int'($urandom_range(top, 0)), 1'($urandom)),
                        make_lit(int'($urandom_range(top, 0)), 1'($urandom)),
                        make_lit(int'($urandom_range(top, 0)), 1'($urandom)));
        end
        run_solver(3, seen);
        if (seen)
            check_result(3);
        finish_test(sat_o ? "random (sat)" : "random (unsat)", e0);
    endtask

    task automatic solve_empty_bins();
        int e0;
        bit seen;
        e0 = err_count;
        clear_clauses();
        run_solver(NUM_BINS, seen);
        if (seen)
        begin
            check_result(NUM_BINS);
            check_value("assign_o", 32'(assign_o), 32'(0));
        end
        finish_test("empty_run", e0);
    endtask

    initial
    begin
        rst          = 1'b0;
        cfg_we_i     = 1'b0;
        cfg_addr_i   = '0;
        cfg_clause_i = '0;
        nb_bins_i    = '0;
        start_i      = 1'b0;
        err_count    = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(58));
        clear_clauses();

        check_after_reset();
        solve_forced_bin();
        solve_with_backtrack();
        detect_unsat();
        solve_random_bins();
        solve_empty_bins();

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin : watchdog
        bm_state_e st;
        #(WATCHDOG_NS);
        st = dut_i.u_ctrl.state_r;
        $display("timeout after %0d ns, controller stuck in state %s", WATCHDOG_NS, st.name());
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- src.f
logic/sat_pkg.sv
logic/bm_ctrl_pkg.sv
logic/clause_lane.sv
logic/clause_store.sv
logic/bin_search.sv
logic/bin_ctrl.sv
logic/bin_solver_top.sv
testbench/tb_bin_solver.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_bin_solver -f src.f -o sim_bin_solver > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_bin_solver > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
